// File: rtl/valu_config.svh
`ifndef VALU_CONFIG_SVH
`define VALU_CONFIG_SVH

// One operand or result double-word
`define VALU_DWORD_W 64

// Function code and element width fields
`define VALU_FUNCT_W 6
`define VALU_WW_W 2

// Element widths below the full double-word
`define VALU_BYTE_W 8
`define VALU_HALF_W 16
`define VALU_WORD_W 32

`endif

// File: rtl/valu_pkg.sv
`include "valu_config.svh"

package valu_pkg;

	// Bit 0 is the most significant bit, element 0 sits at the top
	typedef logic [0:`VALU_DWORD_W-1] dword_t;
	typedef logic [0:`VALU_WORD_W-1] word_t;
	typedef logic [0:`VALU_HALF_W-1] half_t;
	typedef logic [0:`VALU_BYTE_W-1] byte_t;

	// Register-ALU function codes
	typedef enum logic [0:`VALU_FUNCT_W-1] {
		vand   = 6'd1,
		vor    = 6'd2,
		vxor   = 6'd3,
		vnot   = 6'd4,
		vmov   = 6'd5,
		vadd   = 6'd6,
		vsub   = 6'd7,
		vmuleu = 6'd8,
		vmulou = 6'd9,
		vrtth  = 6'd13
	} funct_t;

	typedef enum logic [0:`VALU_WW_W-1] {
		w8  = 2'd0,
		w16 = 2'd1,
		w32 = 2'd2,
		w64 = 2'd3
	} width_t;

endpackage

// File: rtl/valu_addsub.sv
`timescale 1ns/1ps

`include "valu_config.svh"

module valu_addsub (
	input  valu_pkg::dword_t src_a,
	input  valu_pkg::dword_t src_b,
	input  valu_pkg::funct_t funct,
	input  valu_pkg::width_t ww,
	output valu_pkg::dword_t sum
);

	localparam int NUM_BYTES = `VALU_DWORD_W / `VALU_BYTE_W;

	logic                   active;
	logic                   is_sub;
	valu_pkg::dword_t       b_op;
	logic [0:NUM_BYTES-1]   lane_cut;

	assign is_sub = (funct == valu_pkg::vsub);
	assign active = (funct == valu_pkg::vadd) || is_sub;

	// Two's complement subtract: invert here, carry of one per element below
	assign b_op = is_sub ? ~src_b : src_b;

	// Byte k is the lowest byte of its element when lane_cut[k] is set
	always_comb begin
		case (ww)
			valu_pkg::w8:  lane_cut = 8'b1111_1111;
			valu_pkg::w16: lane_cut = 8'b0101_0101;
			valu_pkg::w32: lane_cut = 8'b0001_0001;
			default:       lane_cut = 8'b0000_0001;
		endcase
	end

	// Byte-sliced carry chain, walked from the least significant byte up
	always_comb begin
		logic carry;
		logic cin;
		logic [0:`VALU_BYTE_W] partial;
		carry = 1'b0;
		cin = 1'b0;
		partial = '0;
		sum = '0;
		if (active) begin
			for (int k = NUM_BYTES - 1; k >= 0; k--) begin
				cin = lane_cut[k] ? is_sub : carry;
				partial = {1'b0, src_a[k * `VALU_BYTE_W +: `VALU_BYTE_W]}
					+ {1'b0, b_op[k * `VALU_BYTE_W +: `VALU_BYTE_W]}
					+ {{`VALU_BYTE_W{1'b0}}, cin};
				carry = partial[0];
				sum[k * `VALU_BYTE_W +: `VALU_BYTE_W] = partial[1:`VALU_BYTE_W];
			end
		end
	end

endmodule

// File: rtl/valu_mult.sv
`timescale 1ns/1ps

`include "valu_config.svh"

module valu_mult (
	input  valu_pkg::dword_t src_a,
	input  valu_pkg::dword_t src_b,
	input  valu_pkg::funct_t funct,
	input  valu_pkg::width_t ww,
	output valu_pkg::dword_t product
);

	// Number of double-width products per width
	localparam int PAIRS_8  = `VALU_DWORD_W / `VALU_HALF_W;
	localparam int PAIRS_16 = `VALU_DWORD_W / `VALU_WORD_W;

	logic active;
	logic odd_sel;

	assign odd_sel = (funct == valu_pkg::vmulou);
	assign active  = (funct == valu_pkg::vmuleu) || odd_sel;

	// Element 2j (even) or 2j+1 (odd) feeds product slot j
	always_comb begin
		valu_pkg::byte_t a8;
		valu_pkg::byte_t b8;
		valu_pkg::half_t a16;
		valu_pkg::half_t b16;
		valu_pkg::word_t a32;
		valu_pkg::word_t b32;
		int sel;
		a8 = '0;
		b8 = '0;
		a16 = '0;
		b16 = '0;
		a32 = '0;
		b32 = '0;
		sel = odd_sel ? 1 : 0;
		product = '0;
		if (active) begin
			case (ww)
				valu_pkg::w8: begin
					for (int j = 0; j < PAIRS_8; j++) begin
						a8 = src_a[(2 * j + sel) * `VALU_BYTE_W +: `VALU_BYTE_W];
						b8 = src_b[(2 * j + sel) * `VALU_BYTE_W +: `VALU_BYTE_W];
						product[j * `VALU_HALF_W +: `VALU_HALF_W] =
							valu_pkg::half_t'(a8) * valu_pkg::half_t'(b8);
					end
				end
				valu_pkg::w16: begin
					for (int j = 0; j < PAIRS_16; j++) begin
						a16 = src_a[(2 * j + sel) * `VALU_HALF_W +: `VALU_HALF_W];
						b16 = src_b[(2 * j + sel) * `VALU_HALF_W +: `VALU_HALF_W];
						product[j * `VALU_WORD_W +: `VALU_WORD_W] =
							valu_pkg::word_t'(a16) * valu_pkg::word_t'(b16);
					end
				end
				valu_pkg::w32: begin
					a32 = src_a[sel * `VALU_WORD_W +: `VALU_WORD_W];
					b32 = src_b[sel * `VALU_WORD_W +: `VALU_WORD_W];
					product = valu_pkg::dword_t'(a32) * valu_pkg::dword_t'(b32);
				end
				// No 64x64 multiply, result stays zero
				default: product = '0;
			endcase
		end
	end

endmodule

// File: rtl/valu_logic_rot.sv
`timescale 1ns/1ps

`include "valu_config.svh"

module valu_logic_rot (
	input  valu_pkg::dword_t src_a,
	input  valu_pkg::dword_t src_b,
	input  valu_pkg::funct_t funct,
	input  valu_pkg::width_t ww,
	output valu_pkg::dword_t logic_out
);

	// Swap the upper and lower halves inside every element
	function automatic valu_pkg::dword_t swap_halves(
		input valu_pkg::dword_t v,
		input valu_pkg::width_t w
	);
		valu_pkg::dword_t r;
		int elem_w;
		int half_w;
		int off;
		elem_w = `VALU_BYTE_W << int'(w);
		half_w = elem_w / 2;
		r = '0;
		for (int i = 0; i < `VALU_DWORD_W; i++) begin
			off = i % elem_w;
			r[i] = v[i - off + (off + half_w) % elem_w];
		end
		return r;
	endfunction

	always_comb begin
		case (funct)
			valu_pkg::vand:  logic_out = src_a & src_b;
			valu_pkg::vor:   logic_out = src_a | src_b;
			valu_pkg::vxor:  logic_out = src_a ^ src_b;
			valu_pkg::vnot:  logic_out = ~src_a;
			valu_pkg::vmov:  logic_out = src_a;
			valu_pkg::vrtth: logic_out = swap_halves(src_a, ww);
			default:         logic_out = '0;
		endcase
	end

endmodule

// File: rtl/valu_writeback.sv
`timescale 1ns/1ps

module valu_writeback (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  valu_pkg::funct_t funct,
	input  valu_pkg::dword_t sum,
	input  valu_pkg::dword_t product,
	input  valu_pkg::dword_t logic_out,
	output valu_pkg::dword_t result,
	output logic             out_valid
);

	valu_pkg::dword_t selected;

	// Unkept codes land on logic_out, which is zero for them
	always_comb begin
		case (funct)
			valu_pkg::vadd,
			valu_pkg::vsub:   selected = sum;
			valu_pkg::vmuleu,
			valu_pkg::vmulou: selected = product;
			default:          selected = logic_out;
		endcase
	end

	// Single execute-to-next-stage register
	always_ff @(posedge clk) begin
		if (rst) begin
			result    <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				result <= selected;
			end
		end
	end

endmodule

// File: rtl/valu_top.sv
`timescale 1ns/1ps

module valu_top (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  valu_pkg::funct_t funct,
	input  valu_pkg::width_t ww,
	input  valu_pkg::dword_t src_a,
	input  valu_pkg::dword_t src_b,
	output valu_pkg::dword_t result,
	output logic             out_valid
);

	valu_pkg::dword_t sum;
	valu_pkg::dword_t product;
	valu_pkg::dword_t logic_out;

	// Lane-partitioned add and subtract
	valu_addsub i_addsub (
		.src_a (src_a),
		.src_b (src_b),
		.funct (funct),
		.ww    (ww),
		.sum   (sum)
	);

	// Even and odd widening multiply
	valu_mult i_mult (
		.src_a   (src_a),
		.src_b   (src_b),
		.funct   (funct),
		.ww      (ww),
		.product (product)
	);

	valu_logic_rot i_logic_rot (
		.src_a     (src_a),
		.src_b     (src_b),
		.funct     (funct),
		.ww        (ww),
		.logic_out (logic_out)
	);

	// Result select and output register
	valu_writeback i_writeback (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.funct     (funct),
		.sum       (sum),
		.product   (product),
		.logic_out (logic_out),
		.result    (result),
		.out_valid (out_valid)
	);

endmodule

// File: bench/valu_checker.sv
`timescale 1ns/1ps

`include "valu_config.svh"

module valu_checker (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  valu_pkg::funct_t funct,
	input  valu_pkg::width_t ww,
	input  valu_pkg::dword_t src_a,
	input  valu_pkg::dword_t src_b,
	input  valu_pkg::dword_t result,
	input  logic             out_valid,
	output int               value_errors,
	output int               strobe_errors,
	output int               checked,
	output int               pending
);

	typedef logic [`VALU_DWORD_W-1:0] vec_t;

	vec_t expq[$];
	vec_t exp_result;
	logic exp_valid;
	logic armed;

	function automatic vec_t lane_mask(input int w);
		if (w >= `VALU_DWORD_W) begin
			return '1;
		end
		return (vec_t'(1) << w) - vec_t'(1);
	endfunction

	// Element 0 is the most significant lane
	function automatic vec_t get_elem(input vec_t v, input int e, input int w);
		return (v >> (`VALU_DWORD_W - (e + 1) * w)) & lane_mask(w);
	endfunction

	function automatic vec_t put_elem(input vec_t acc, input vec_t x,
		input int e, input int w);
		return acc | ((x & lane_mask(w)) << (`VALU_DWORD_W - (e + 1) * w));
	endfunction

	function automatic int lane_bits(input valu_pkg::width_t w);
		case (w)
			valu_pkg::w8:  return `VALU_BYTE_W;
			valu_pkg::w16: return `VALU_HALF_W;
			valu_pkg::w32: return `VALU_WORD_W;
			default:       return `VALU_DWORD_W;
		endcase
	endfunction

	function automatic vec_t model(input valu_pkg::funct_t f, input valu_pkg::width_t wsel,
		input vec_t a, input vec_t b);
		vec_t r;
		vec_t x;
		vec_t y;
		int w;
		int n;
		int odd;
		w = lane_bits(wsel);
		n = `VALU_DWORD_W / w;
		odd = (f == valu_pkg::vmulou) ? 1 : 0;
		r = '0;
		case (f)
			valu_pkg::vand: r = a & b;
			valu_pkg::vor:  r = a | b;
			valu_pkg::vxor: r = a ^ b;
			valu_pkg::vnot: r = ~a;
			valu_pkg::vmov: r = a;
			valu_pkg::vadd, valu_pkg::vsub: begin
				for (int e = 0; e < n; e++) begin
					x = get_elem(a, e, w);
					y = get_elem(b, e, w);
					r = put_elem(r, (f == valu_pkg::vadd) ? x + y : x - y, e, w);
				end
			end
			valu_pkg::vmuleu, valu_pkg::vmulou: begin
				// Full-width lanes have no widening product
				if (w < `VALU_DWORD_W) begin
					for (int j = 0; j < n / 2; j++) begin
						x = get_elem(a, 2 * j + odd, w);
						y = get_elem(b, 2 * j + odd, w);
						r = put_elem(r, x * y, j, 2 * w);
					end
				end
			end
			valu_pkg::vrtth: begin
				for (int e = 0; e < n; e++) begin
					x = get_elem(a, e, w);
					r = put_elem(r, (x << (w / 2)) | (x >> (w / 2)), e, w);
				end
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	initial begin
		value_errors = 0;
		strobe_errors = 0;
		checked = 0;
		pending = 0;
		armed = 1'b0;
		exp_valid = 1'b0;
		exp_result = '0;
	end

	always @(posedge clk) begin
		if (rst) begin
			armed = 1'b1;
			exp_valid = 1'b0;
			exp_result = '0;
			expq.delete();
		end else begin
			exp_valid = in_valid;
			if (in_valid) begin
				expq.push_back(model(funct, ww, src_a, src_b));
			end
		end
		// Output register has settled shortly after the edge
		#1;
		if (armed) begin
			// Each output strobe retires the oldest accepted operation
			if (out_valid === 1'b1 && expq.size() != 0) begin
				exp_result = expq.pop_front();
				checked++;
			end
			if (out_valid !== exp_valid) begin
				strobe_errors++;
				$display("At %0t out_valid was %b but should be %b",
					$time, out_valid, exp_valid);
			end
			if (vec_t'(result) !== exp_result) begin
				value_errors++;
				$display("[ERROR] %0t: wrong result, expected %h, actual %h",
					$time, exp_result, result);
			end
		end
		pending = expq.size();
	end

endmodule

// File: bench/valu_tb.sv
`timescale 1ns/1ps

module valu_tb;

	localparam int NUM_OPS = 2000;
	localparam int RESET_CYCLES = 8;
	localparam int RESET_TIMEOUT = 50;
	localparam int RUN_TIMEOUT = 5000;
	localparam int DRAIN_TIMEOUT = 20;

	logic             clk;
	logic             rst;
	logic             in_valid;
	valu_pkg::funct_t funct;
	valu_pkg::width_t ww;
	valu_pkg::dword_t src_a;
	valu_pkg::dword_t src_b;
	valu_pkg::dword_t result;
	logic             out_valid;

	int value_errors;
	int strobe_errors;
	int checked;
	int pending;
	int issued;
	int timeouts;

	always #5 clk = ~clk;

	valu_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.funct     (funct),
		.ww        (ww),
		.src_a     (src_a),
		.src_b     (src_b),
		.result    (result),
		.out_valid (out_valid)
	);

	valu_checker i_checker (
		.clk           (clk),
		.rst           (rst),
		.in_valid      (in_valid),
		.funct         (funct),
		.ww            (ww),
		.src_a         (src_a),
		.src_b         (src_b),
		.result        (result),
		.out_valid     (out_valid),
		.value_errors  (value_errors),
		.strobe_errors (strobe_errors),
		.checked       (checked),
		.pending       (pending)
	);

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

	task automatic drive_op(input valu_pkg::funct_t f, input valu_pkg::width_t w,
		input valu_pkg::dword_t a, input valu_pkg::dword_t b);
		@(negedge clk);
		in_valid = 1'b1;
		funct = f;
		ww = w;
		src_a = a;
		src_b = b;
		issued++;
	endtask

	function automatic valu_pkg::funct_t pick_funct();
		logic [5:0] code;
		if ($urandom % 16 == 0) begin
			// Codes outside the kept set
			case ($urandom % 4)
				0:       code = 6'd0;
				1:       code = 6'd11;
				2:       code = 6'd14;
				default: code = 6'd63;
			endcase
			return valu_pkg::funct_t'(code);
		end
		case ($urandom % 10)
			0:       return valu_pkg::vand;
			1:       return valu_pkg::vor;
			2:       return valu_pkg::vxor;
			3:       return valu_pkg::vnot;
			4:       return valu_pkg::vmov;
			5:       return valu_pkg::vadd;
			6:       return valu_pkg::vsub;
			7:       return valu_pkg::vmuleu;
			8:       return valu_pkg::vmulou;
			default: return valu_pkg::vrtth;
		endcase
	endfunction

	// All-ones lanes push a carry or borrow out of every element
	task automatic directed_carry_checks();
		valu_pkg::width_t w;
		valu_pkg::dword_t lane_ones [4];
		lane_ones[0] = 64'h0101_0101_0101_0101;
		lane_ones[1] = 64'h0001_0001_0001_0001;
		lane_ones[2] = 64'h0000_0001_0000_0001;
		lane_ones[3] = 64'h0000_0000_0000_0001;
		w = w.first();
		for (int k = 0; k < 4; k++) begin
			drive_op(valu_pkg::vadd, w, '1, '1);
			drive_op(valu_pkg::vadd, w, '1, lane_ones[k]);
			drive_op(valu_pkg::vsub, w, '0, '1);
			drive_op(valu_pkg::vsub, w, '0, lane_ones[k]);
			w = w.next();
		end
	endtask

	task automatic random_ops();
		int cycles;
		cycles = 0;
		while (issued < NUM_OPS && cycles < RUN_TIMEOUT) begin
			if ($urandom % 10 < 8) begin
				drive_op(pick_funct(), valu_pkg::width_t'(2'($urandom % 4)),
					{$urandom, $urandom}, {$urandom, $urandom});
			end else begin
				@(negedge clk);
				in_valid = 1'b0;
				src_a = {$urandom, $urandom};
			end
			cycles++;
		end
		if (issued < NUM_OPS) begin
			$display("Timeout: only %0d of %0d operations issued", issued, NUM_OPS);
			timeouts++;
		end
	endtask

	task automatic drain_pipeline();
		int cycles;
		@(negedge clk);
		in_valid = 1'b0;
		cycles = 0;
		while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (pending != 0) begin
			$display("Timeout: %0d expected results never came out", pending);
			timeouts++;
		end
		// Let the checker see the strobe drop
		@(negedge clk);
	endtask

	task automatic finish_run();
		$display(
			"Summary: %0d issued, %0d checked, %0d value errors, %0d strobe errors, %0d timeouts",
			issued, checked, value_errors, strobe_errors, timeouts);
		if (timeouts != 0 || value_errors != 0 || strobe_errors != 0 || checked != issued) begin
			$display("*** FAILED ***");
		end else begin
			$display("*** PASSED ***");
		end
		$finish;
	endtask

	initial begin
		int cycles;
		clk = 1'b0;
		in_valid = 1'b0;
		funct = valu_pkg::vand;
		ww = valu_pkg::w8;
		src_a = '0;
		src_b = '0;
		issued = 0;
		timeouts = 0;
		void'($urandom(32'hfa92));
		cycles = 0;
		while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (rst !== 1'b0) begin
			$display("Timeout: reset was not released within %0d cycles",
				RESET_TIMEOUT);
			timeouts++;
		end else begin
			directed_carry_checks();
			random_ops();
			drain_pipeline();
		end
		finish_run();
	end

endmodule

// File: tb.f
+incdir+rtl
rtl/valu_pkg.sv
rtl/valu_addsub.sv
rtl/valu_mult.sv
rtl/valu_logic_rot.sv
rtl/valu_writeback.sv
rtl/valu_top.sv
bench/valu_checker.sv
bench/valu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f tb.f --top-module valu_tb -o valu_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/valu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
